/* testbench/vec_trace.txt */
# W reg hex: host write | N reg: random write | R reg hex: read, expected | M reg: read vs model
# C sew avl: config | X op vd vs1 vs2: command | B op vd vs1 vs2 sew avl | L reg vl: lane count
W 1 0123456789abcdeffedcba9876543210
W 2 ffffffffffffffffffffffffffffffff
W 3 01010101010101010101010101010101
W 30 00000000000000000000000000000000
W 28 00000001000000020000000300000004
R 1 0123456789abcdeffedcba9876543210
R 2 ffffffffffffffffffffffffffffffff
R 3 01010101010101010101010101010101
N 4
N 5
N 6
N 7
M 4
M 7
C 0 16
X 0 8 2 3
R 8 00000000000000000000000000000000
X 1 9 30 3
R 9 ffffffffffffffffffffffffffffffff
C 1 31
X 0 10 2 3
R 10 01000100010001000100010001000100
C 2 31
X 0 11 2 3
R 11 01010100010101000101010001010100
C 0 16
X 0 12 4 5
X 1 13 4 5
X 5 14 4 5
X 6 15 6 7
M 12
M 13
M 14
M 15
C 1 16
X 2 16 4 5
X 3 17 5 6
X 6 18 4 7
X 1 19 6 4
M 16
M 17
M 18
M 19
C 2 16
X 4 20 4 5
X 5 21 6 7
X 0 22 5 7
M 20
M 21
M 22
C 0 5
X 3 23 2 30
L 23 5
C 1 3
X 3 24 2 2
L 24 3
C 2 0
X 3 25 2 2
L 25 0
C 0 16
B 3 26 2 2 1 2
R 26 ffffffffffffffffffffffffffffffff
X 3 27 2 2
L 27 2
R 27 000000000000000000000000ffffffff
C 2 16
X 0 4 4 5
M 4
X 1 5 4 5
M 5
X 4 28 28 28
R 28 00000000000000000000000000000000

/* list.f */
verilog/vec_pkg.sv
verilog/vec_regfile.sv
verilog/vec_cfg.sv
verilog/vec_alu.sv
verilog/vec_sequencer.sv
verilog/vec_unit.sv
testbench/vec_clk_gen.sv
testbench/vec_unit_checker.sv
testbench/vec_unit_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run from the project root, verdict from the log
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module vec_unit_tb \
  -f list.f -o vec_unit_sim > sim.log 2>&1 &&
  ./obj_dir/vec_unit_sim >> sim.log 2>&1 ||
  echo "build or run returned an error" >> sim.log
cat sim.log
grep -qx "STATUS: PASS" sim.log && exit 0 || exit 1

/* testbench/vec_unit_tb.sv */
`timescale 1ns/1ps

module vec_unit_tb;

  import vec_pkg::*;

  logic       clk;
  logic       rst_n;
  logic       cfg_we;
  sew_e       cfg_sew;
  vl_t        cfg_avl;
  logic       cmd_valid;
  vcmd_t      cmd;
  vhost_req_t host;
  vreg_t      rdata;
  logic       rvalid;
  logic       busy;
  logic       done;

  // reference state
  vreg_t model_rf [NUM_VREGS];
  int    m_sew;
  int    m_vl;

  int    n_mismatch;
  int    n_other;
  int    cycles;
  int    limit;
  string lines [$];

  vec_clk_gen u_vec_clk_gen (
    .clk   (clk),
    .rst_n (rst_n)
  );

  vec_unit u_vec_unit (
    .clk       (clk),
    .rst_n     (rst_n),
    .cfg_we    (cfg_we),
    .cfg_sew   (cfg_sew),
    .cfg_avl   (cfg_avl),
    .cmd_valid (cmd_valid),
    .cmd       (cmd),
    .host      (host),
    .rdata     (rdata),
    .rvalid    (rvalid),
    .busy      (busy),
    .done      (done)
  );

  task automatic check_vreg(input string name, input vreg_t got, input vreg_t exp);
    if (got !== exp) begin
      n_mismatch++;
      $display("FAILED %0t %s exp %h got %h", $time, name, exp, got);
    end
  endtask

  task automatic check_cfg_len(input string name, input vl_t got, input vl_t exp);
    if (got !== exp) begin
      n_mismatch++;
      $display("FAILED %0t %s exp %0d got %0d", $time, name, exp, got);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      n_mismatch++;
      $display("FAILED %0t %s exp %b got %b", $time, name, exp, got);
    end
  endtask

  task automatic check_count(input string name, input int got, input int exp);
    if (got != exp) begin
      n_mismatch++;
      $display("FAILED %0t %s exp %0d got %0d", $time, name, exp, got);
    end
  endtask

  // reserved code behaves as 32-bit
  function automatic int lane_bits(input int s);
    if (s == 0) begin
      return 8;
    end else if (s == 1) begin
      return 16;
    end
    return 32;
  endfunction

  // element-wise reference, lanes kept apart by masking
  function automatic vreg_t ref_op(input int op, input int ew, input int vl,
                                   input vreg_t a, input vreg_t b);
    vreg_t           res;
    longint unsigned x;
    longint unsigned y;
    longint unsigned r;
    longint unsigned m;
    res = '0;
    m = (64'd1 << ew) - 1;
    for (int i = 0; i < VLEN / ew; i++) begin
      x = 64'(a >> (i * ew)) & m;
      y = 64'(b >> (i * ew)) & m;
      case (op)
        0: r = x + y;
        1: r = x - y;
        2: r = x & y;
        3: r = x | y;
        4: r = x ^ y;
        5: r = (x < y) ? x : y;
        6: r = (x > y) ? x : y;
        default: r = 0;
      endcase
      r = r & m;
      // tail lanes stay zero
      if (i < vl) begin
        res = res | (vreg_t'(r) << (i * ew));
      end
    end
    return res;
  endfunction

  // vsetvli style clamp
  task automatic model_cfg(input int s, input int avl);
    int vmax;
    m_sew = (s > 2) ? 2 : s;
    vmax = VLEN / lane_bits(m_sew);
    m_vl = (avl > vmax) ? vmax : avl;
  endtask

  task automatic host_write(input int r, input vreg_t d);
    @(negedge clk);
    host = '{en: 1'b1, rw: 1'b1, addr: vreg_addr_t'(r), wdata: d};
    @(negedge clk);
    host = '0;
    model_rf[r] = d;
  endtask

  // data and rvalid show up the cycle after the sampling edge
  task automatic host_read(input int r, output vreg_t d);
    @(negedge clk);
    host = '{en: 1'b1, rw: 1'b0, addr: vreg_addr_t'(r), wdata: '0};
    @(negedge clk);
    host = '0;
    check_bit("rvalid", rvalid, 1'b1);
    d = rdata;
  endtask

  task automatic config_write(input int s, input int avl);
    @(negedge clk);
    cfg_we  = 1'b1;
    cfg_sew = sew_e'(s);
    cfg_avl = vl_t'(avl);
    @(negedge clk);
    cfg_we = 1'b0;
    model_cfg(s, avl);
  endtask

  // optional cfg write lands one cycle into the command
  task automatic run_cmd(input int op, input int vd, input int vs1, input int vs2,
                         input bit late_cfg, input int s, input int avl);
    vreg_t exp;
    int    n;
    exp = ref_op(op, lane_bits(m_sew), m_vl, model_rf[vs1], model_rf[vs2]);
    @(negedge clk);
    cmd_valid = 1'b1;
    cmd = '{op: vop_e'(op), vd: vreg_addr_t'(vd), vs1: vreg_addr_t'(vs1),
            vs2: vreg_addr_t'(vs2)};
    n = 0;
    do begin
      @(negedge clk);
      n++;
      cmd_valid = 1'b0;
      cfg_we = late_cfg && (n == 1);
      cfg_sew = sew_e'(s);
      cfg_avl = vl_t'(avl);
      if (!done) begin
        check_bit("busy", busy, 1'b1);
      end
    end while (!done && n < 10);
    cfg_we = 1'b0;
    if (!done) begin
      n_other++;
      $display("command to v%0d never signalled done", vd);
    end else begin
      check_bit("busy", busy, 1'b0);
      check_count("latency", n - 1, 4);
    end
    model_rf[vd] = exp;
    if (late_cfg) begin
      model_cfg(s, avl);
    end
  endtask

  task automatic lane_count(input int r, input int evl);
    vreg_t d;
    int    ew;
    int    cnt;
    host_read(r, d);
    ew = lane_bits(m_sew);
    cnt = 0;
    for (int i = 0; i < VLEN / ew; i++) begin
      if (((d >> (i * ew)) & ((vreg_t'(1) << ew) - 1)) != 0) begin
        cnt++;
      end
    end
    check_cfg_len("vl", vl_t'(cnt), vl_t'(evl));
  endtask

  task automatic run_line(input string line);
    byte   k;
    string rest;
    int    a0;
    int    a1;
    int    a2;
    int    a3;
    int    a4;
    int    a5;
    vreg_t d;
    vreg_t got;
    k = line.getc(0);
    rest = line.substr(1, line.len() - 1);
    case (k)
      "W": begin
        void'($sscanf(rest, "%d %h", a0, d));
        host_write(a0, d);
      end
      "N": begin
        void'($sscanf(rest, "%d", a0));
        d = {$urandom(), $urandom(), $urandom(), $urandom()};
        host_write(a0, d);
      end
      "R": begin
        void'($sscanf(rest, "%d %h", a0, d));
        host_read(a0, got);
        check_vreg("rdata", got, d);
      end
      "M": begin
        void'($sscanf(rest, "%d", a0));
        host_read(a0, got);
        check_vreg("rdata", got, model_rf[a0]);
      end
      "C": begin
        void'($sscanf(rest, "%d %d", a0, a1));
        config_write(a0, a1);
      end
      "X": begin
        void'($sscanf(rest, "%d %d %d %d", a0, a1, a2, a3));
        run_cmd(a0, a1, a2, a3, 1'b0, 0, 0);
      end
      "B": begin
        void'($sscanf(rest, "%d %d %d %d %d %d", a0, a1, a2, a3, a4, a5));
        run_cmd(a0, a1, a2, a3, 1'b1, a4, a5);
      end
      "L": begin
        void'($sscanf(rest, "%d %d", a0, a1));
        lane_count(a0, a1);
      end
      default: begin
        n_other++;
        $display("unknown trace line: %s", line);
      end
    endcase
  endtask

  initial begin
    int    fd;
    string line;
    cfg_we     = 1'b0;
    cfg_sew    = SEW32;
    cfg_avl    = '0;
    cmd_valid  = 1'b0;
    cmd        = '0;
    host       = '0;
    n_mismatch = 0;
    n_other    = 0;
    limit      = 0;
    model_cfg(2, 4);
    void'($urandom(32'h5c0df839));
    fd = $fopen("testbench/vec_trace.txt", "r");
    if (fd == 0) begin
      n_other++;
      $display("cannot open the trace file");
    end else begin
      while (!$feof(fd)) begin
        if ($fgets(line, fd) > 0) begin
          lines.push_back(line);
        end
      end
      $fclose(fd);
    end
    // 20 cycles per line on top of reset
    limit = 20 * lines.size() + 16 + 4;
    wait (rst_n === 1'b1);
    foreach (lines[i]) begin
      if (lines[i].len() > 1 && lines[i].getc(0) != "#") begin
        run_line(lines[i]);
      end
    end
    repeat (2) @(negedge clk);
    $display("errors: %0d mismatches, %0d other", n_mismatch, n_other);
    if (n_mismatch == 0 && n_other == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

  // run limit
  initial begin
    cycles = 0;
    forever begin
      @(posedge clk);
      cycles++;
      if (limit > 0 && cycles > limit) begin
        n_other++;
        $display("timeout after %0d cycles", cycles);
        $display("errors: %0d mismatches, %0d other", n_mismatch, n_other);
        $display("STATUS: FAIL");
        $finish;
      end
    end
  end

endmodule

/* testbench/vec_unit_checker.sv */
`timescale 1ns/1ps

module vec_unit_checker (
  input logic                clk,
  input logic                rst_n,
  input logic                accept,
  input logic                wb_fire,
  input logic                busy,
  input logic                done,
  input logic                rvalid,
  input vec_pkg::vhost_req_t host,
  input vec_pkg::vrf_port_t  rf_port
);

  // write edge comes exactly 4 cycles after acceptance
  a_latency : assert property (@(posedge clk) disable iff (!rst_n)
    $past(accept, 4) |-> wb_fire)
    else $error("write edge not 4 cycles after accept");

  // busy with done only when the next command went in at the write edge
  a_done_busy : assert property (@(posedge clk) disable iff (!rst_n)
    (done && busy) |-> $past(accept))
    else $error("busy and done high without a back-to-back accept");

  // host owns the port only while idle
  a_host_idle : assert property (@(posedge clk) disable iff (!rst_n)
    busy |-> !host.en)
    else $error("host access while busy");

  // rvalid only after the port really carried the host read
  a_rvalid : assert property (@(posedge clk) disable iff (!rst_n)
    rvalid |-> $past(!busy && rf_port.en && !rf_port.rw && (rf_port.addr == host.addr)))
    else $error("rvalid without a host read on the register-file port");

endmodule

bind vec_sequencer vec_unit_checker u_vec_unit_checker (
  .clk     (clk),
  .rst_n   (rst_n),
  .accept  (accept),
  .wb_fire (wb_fire),
  .busy    (busy),
  .done    (done),
  .rvalid  (rvalid),
  .host    (host),
  .rf_port (rf_port)
);

/* testbench/vec_clk_gen.sv */
`timescale 1ns/1ps

module vec_clk_gen (
  output logic clk,
  output logic rst_n
);

  // 100 ns period
  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // reset held for 16 cycles, released on a falling edge
  initial begin
    rst_n = 1'b0;
    repeat (16) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
  end

endmodule

/* verilog/vec_unit.sv */
`timescale 1ns/1ps

module vec_unit (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                cfg_we,
  input  vec_pkg::sew_e       cfg_sew,
  input  vec_pkg::vl_t        cfg_avl,
  input  logic                cmd_valid,
  input  vec_pkg::vcmd_t      cmd,
  input  vec_pkg::vhost_req_t host,
  output vec_pkg::vreg_t      rdata,
  output logic                rvalid,
  output logic                busy,
  output logic                done
);

  import vec_pkg::*;

  // active config from the cfg block
  vcfg_t     cfg;
  // latched copies the ALU works on
  vcfg_t     op_cfg;
  vop_e      op;
  vreg_t     op_a;
  vreg_t     op_b;
  vreg_t     alu_result;
  // single register-file port
  vrf_port_t rf_port;

  vec_cfg u_vec_cfg (
    .clk     (clk),
    .rst_n   (rst_n),
    .cfg_we  (cfg_we),
    .cfg_sew (cfg_sew),
    .cfg_avl (cfg_avl),
    .cfg     (cfg)
  );

  // host read data shares the regfile output
  vec_sequencer u_vec_sequencer (
    .clk        (clk),
    .rst_n      (rst_n),
    .cmd_valid  (cmd_valid),
    .cmd        (cmd),
    .cfg        (cfg),
    .host       (host),
    .rf_rdata   (rdata),
    .alu_result (alu_result),
    .rf_port    (rf_port),
    .op_a       (op_a),
    .op_b       (op_b),
    .op_cfg     (op_cfg),
    .op         (op),
    .busy       (busy),
    .done       (done),
    .rvalid     (rvalid)
  );

  vec_alu u_vec_alu (
    .op     (op),
    .cfg    (op_cfg),
    .a      (op_a),
    .b      (op_b),
    .result (alu_result)
  );

  vec_regfile u_vec_regfile (
    .clk   (clk),
    .port  (rf_port),
    .rdata (rdata)
  );

endmodule

/* verilog/vec_sequencer.sv */
`timescale 1ns/1ps

module vec_sequencer (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                cmd_valid,
  input  vec_pkg::vcmd_t      cmd,
  input  vec_pkg::vcfg_t      cfg,
  input  vec_pkg::vhost_req_t host,
  input  vec_pkg::vreg_t      rf_rdata,
  input  vec_pkg::vreg_t      alu_result,
  output vec_pkg::vrf_port_t  rf_port,
  output vec_pkg::vreg_t      op_a,
  output vec_pkg::vreg_t      op_b,
  output vec_pkg::vcfg_t      op_cfg,
  output vec_pkg::vop_e       op,
  output logic                busy,
  output logic                done,
  output logic                rvalid
);

  import vec_pkg::*;

  seq_state_e state;
  seq_state_e state_nxt;

  // WB takes two cycles, first captures vs2, second writes vd
  logic  wb_arm;
  logic  wb_fire;
  logic  accept;
  vcmd_t cmd_q;

  assign busy    = (state != IDLE);
  assign wb_fire = (state == WB) && wb_arm;

  // take a command when idle, or in the write cycle so the next one
  // starts right behind it
  assign accept = cmd_valid && ((state == IDLE) || wb_fire);

  assign op = cmd_q.op;

  always_comb begin
    state_nxt = state;
    case (state)
      IDLE: begin
        if (accept) begin
          state_nxt = RD_A;
        end
      end
      RD_A: state_nxt = RD_B;
      RD_B: state_nxt = WB;
      WB: begin
        if (wb_arm) begin
          state_nxt = accept ? RD_A : IDLE;
        end
      end
      default: state_nxt = IDLE;
    endcase
  end

  // control state
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state  <= IDLE;
      wb_arm <= 1'b0;
      done   <= 1'b0;
      rvalid <= 1'b0;
    end else begin
      state  <= state_nxt;
      wb_arm <= (state == WB) && !wb_arm;
      // pulse for the cycle after the write edge
      done   <= wb_fire;
      // host read data is out one cycle after it was sampled
      rvalid <= (state == IDLE) && host.en && !host.rw;
    end
  end

  // command and config frozen for the whole op
  // later cfg writes only reach the next command
  always_ff @(posedge clk) begin
    if (accept) begin
      cmd_q  <= cmd;
      op_cfg <= cfg;
    end
  end

  // operand capture off the read port
  always_ff @(posedge clk) begin
    if (state == RD_B) begin
      op_a <= rf_rdata;
    end
    if ((state == WB) && !wb_arm) begin
      op_b <= rf_rdata;
    end
  end

  // port mux, host owns it only while idle
  always_comb begin
    rf_port = '0;
    case (state)
      IDLE: rf_port = vrf_port_t'(host);
      RD_A: rf_port = '{en: 1'b1, rw: 1'b0, addr: cmd_q.vs1, wdata: '0};
      RD_B: rf_port = '{en: 1'b1, rw: 1'b0, addr: cmd_q.vs2, wdata: '0};
      // nothing on the port while vs2 data settles
      WB:   rf_port = '{en: wb_arm, rw: 1'b1, addr: cmd_q.vd, wdata: alu_result};
      default: rf_port = '0;
    endcase
  end

endmodule

/* verilog/vec_alu.sv */
`timescale 1ns/1ps

module vec_alu (
  input  vec_pkg::vop_e  op,
  input  vec_pkg::vcfg_t cfg,
  input  vec_pkg::vreg_t a,
  input  vec_pkg::vreg_t b,
  output vec_pkg::vreg_t result
);

  import vec_pkg::*;

  // one lane op at 32 bits
  // narrower lanes come in zero extended and keep the low bits,
  // so add/sub wrap in the lane and unsigned min/max stay exact
  function automatic logic [31:0] lane_op(
    input vop_e        f,
    input logic [31:0] x,
    input logic [31:0] y
  );
    logic [31:0] r;
    case (f)
      VADD:    r = x + y;
      VSUB:    r = x - y;
      VAND:    r = x & y;
      VOR:     r = x | y;
      VXOR:    r = x ^ y;
      VMINU:   r = (x < y) ? x : y;
      VMAXU:   r = (x > y) ? x : y;
      default: r = '0;
    endcase
    return r;
  endfunction

  // one result per element width
  // w = 0, 1, 2 gives 8, 16, 32-bit lanes
  for (genvar w = 0; w < 3; w++) begin : g_width
    localparam int EW = 8 << w;
    localparam int NL = VLEN / EW;

    vreg_t res;

    for (genvar i = 0; i < NL; i++) begin : g_lane
      logic [31:0] t;

      // lanes are independent, no carry crosses a boundary
      assign t = lane_op(op, 32'(a[i*EW +: EW]), 32'(b[i*EW +: EW]));

      // tail lanes at or past vl read as zero
      assign res[i*EW +: EW] = (vl_t'(i) < cfg.vl) ? t[EW-1:0] : '0;
    end
  end

  // pick by active width
  // reserved width code follows 32-bit
  always_comb begin
    case (cfg.sew)
      SEW8:    result = g_width[0].res;
      SEW16:   result = g_width[1].res;
      default: result = g_width[2].res;
    endcase
  end

endmodule

/* verilog/vec_cfg.sv */
`timescale 1ns/1ps

module vec_cfg (
  input  logic           clk,
  input  logic           rst_n,
  input  logic           cfg_we,
  input  vec_pkg::sew_e  cfg_sew,
  input  vec_pkg::vl_t   cfg_avl,
  output vec_pkg::vcfg_t cfg
);

  import vec_pkg::*;

  sew_e sew_eff;
  vl_t  vl_max;
  vl_t  vl_new;

  // legalize width, reserved code acts as 32-bit
  always_comb begin
    case (cfg_sew)
      SEW8:    sew_eff = SEW8;
      SEW16:   sew_eff = SEW16;
      default: sew_eff = SEW32;
    endcase
  end

  // lane count for the chosen width
  always_comb begin
    case (sew_eff)
      SEW8:    vl_max = VLMAX_SEW8;
      SEW16:   vl_max = VLMAX_SEW16;
      default: vl_max = VLMAX_SEW32;
    endcase
  end

  // vl = min(avl, vlmax), like vsetvli
  assign vl_new = (cfg_avl > vl_max) ? vl_max : cfg_avl;

  // new config seen from the next cycle
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      cfg <= CFG_RESET;
    end else if (cfg_we) begin
      cfg <= '{sew: sew_eff, vl: vl_new};
    end
  end

endmodule

/* verilog/vec_regfile.sv */
`timescale 1ns/1ps

module vec_regfile (
  input  logic               clk,
  input  vec_pkg::vrf_port_t port,
  output vec_pkg::vreg_t     rdata
);

  import vec_pkg::*;

  // one entry per vector register
  vreg_t mem [NUM_VREGS];

  // write lands at the sampling edge
  always_ff @(posedge clk) begin
    if (port.en && port.rw) begin
      mem[port.addr] <= port.wdata;
    end
  end

  // registered read, data valid the cycle after
  // rdata holds between reads
  always_ff @(posedge clk) begin
    if (port.en && !port.rw) begin
      rdata <= mem[port.addr];
    end
  end

endmodule

/* verilog/vec_pkg.sv */
package vec_pkg;

  // register file geometry
  localparam int VLEN      = 128;
  localparam int NUM_VREGS = 32;
  localparam int VREG_AW   = 5;

  typedef logic [VLEN-1:0]    vreg_t;
  typedef logic [VREG_AW-1:0] vreg_addr_t;

  // element count, 0 to 16
  typedef logic [4:0] vl_t;

  // last code is reserved, treated as SEW32
  typedef enum logic [1:0] {
    SEW8     = 2'b00,
    SEW16    = 2'b01,
    SEW32    = 2'b10,
    SEW_RSVD = 2'b11
  } sew_e;

  typedef enum logic [2:0] {
    VADD  = 3'd0,
    VSUB  = 3'd1,
    VAND  = 3'd2,
    VOR   = 3'd3,
    VXOR  = 3'd4,
    VMINU = 3'd5,
    VMAXU = 3'd6
  } vop_e;

  // per-width element limits
  localparam vl_t VLMAX_SEW8  = vl_t'(VLEN / 8);
  localparam vl_t VLMAX_SEW16 = vl_t'(VLEN / 16);
  localparam vl_t VLMAX_SEW32 = vl_t'(VLEN / 32);

  typedef struct packed {
    sew_e sew;
    vl_t  vl;
  } vcfg_t;

  // state out of reset
  localparam vcfg_t CFG_RESET = '{sew: SEW32, vl: VLMAX_SEW32};

  typedef struct packed {
    vop_e       op;
    vreg_addr_t vd;
    vreg_addr_t vs1;
    vreg_addr_t vs2;
  } vcmd_t;

  // rw high means write
  typedef struct packed {
    logic       en;
    logic       rw;
    vreg_addr_t addr;
    vreg_t      wdata;
  } vhost_req_t;

  typedef struct packed {
    logic       en;
    logic       rw;
    vreg_addr_t addr;
    vreg_t      wdata;
  } vrf_port_t;

  // sequencer states
  typedef enum logic [1:0] {
    IDLE = 2'd0,
    RD_A = 2'd1,
    RD_B = 2'd2,
    WB   = 2'd3
  } seq_state_e;

endpackage
